// File: hdl/core_pkg.sv
package core_pkg;

    // ============================================================
    // Widths
    // ============================================================

    localparam int xlen        = 32;
    localparam int reg_count   = 32;
    localparam int instr_bytes = 4;           // PC step per instruction.

    localparam logic [xlen-1:0] reset_pc = '0;

    typedef logic [$clog2(reg_count)-1:0] reg_addr_t;

    // ============================================================
    // Instruction encodings
    // ============================================================

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,                              // From the execute/memory register.
        FWD_WB                                // From the write-back register.
    } fwd_sel_e;

    // ============================================================
    // Stage registers
    // ============================================================

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] imm;                 // Sign extended.
        reg_addr_t       rs;
        reg_addr_t       rt;
        reg_addr_t       dest;
        alu_op_e         alu_op;
        logic            write_reg;
        logic            mem_read;
        logic            mem_write;
        logic            use_imm;
        logic            branch;
    } id_ex_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] result;
        logic [xlen-1:0] store_data;
        reg_addr_t       dest;
        logic            write_reg;
        logic            mem_read;
        logic            mem_write;
    } ex_mem_t;

    typedef struct packed {
        logic            valid;
        reg_addr_t       dest;
        logic            write_reg;
        logic [xlen-1:0] result;
    } mem_wb_t;

endpackage

// File: hdl/pipe_if.sv
interface pipe_if #(
    parameter type bits_t = logic
);

    bits_t bits;                              // Stage register contents.
    logic  stall;                             // Hold the register.
    logic  flush;                             // Load a bubble.

    // The stage that owns the register.
    modport producer (
        output bits,
        input  stall,
        input  flush
    );

    // Downstream readers. The hazard unit attaches here and
    // is the only one that drives stall and flush.
    modport consumer (
        input  bits,
        output stall,
        output flush
    );

endinterface

// File: hdl/stage_fetch.sv
module stage_fetch
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic            stall,
    input  logic            load,
    input  logic [xlen-1:0] pc_in,
    output logic [xlen-1:0] imem_addr,
    input  logic [xlen-1:0] imem_data,
    output logic [xlen-1:0] instruction,
    output logic [xlen-1:0] pc,
    input  logic            flush
);

    logic [xlen-1:0] pc_reg;

    assign imem_addr = pc_reg;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_reg      <= reset_pc;
            instruction <= '0;                // Decodes as a no-op.
            pc          <= '0;
        end else if (!stall) begin
            if (load) begin
                pc_reg <= pc_in;              // Taken branch.
            end else begin
                pc_reg <= pc_reg + xlen'(instr_bytes);
            end
            instruction <= flush ? '0 : imem_data;
            pc          <= pc_reg;
        end
    end

endmodule

// File: hdl/stage_decode.sv
module stage_decode
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic [xlen-1:0] instruction,
    input  logic [xlen-1:0] pc,
    input  logic            wb_we,
    input  reg_addr_t       wb_dest,
    input  logic [xlen-1:0] wb_data,
    output reg_addr_t       rs,
    output reg_addr_t       rt,
    output logic            uses_rt,
    pipe_if.producer        ex
);

    logic [xlen-1:0] regs [reg_count];
    opcode_e         opcode;
    funct_e          funct;
    reg_addr_t       rd;
    id_ex_t          id_next;

    assign opcode = opcode_e'(instruction[31:26]);
    assign funct  = funct_e'(instruction[5:0]);
    assign rs     = instruction[25:21];
    assign rt     = instruction[20:16];
    assign rd     = instruction[15:11];

    // Register 0 reads as zero; a write in the same cycle passes through.
    function automatic logic [xlen-1:0] read_reg(reg_addr_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb_we && wb_dest == idx) begin
            return wb_data;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (wb_we && wb_dest != '0) begin
            regs[wb_dest] <= wb_data;
        end
    end

    // ============================================================
    // Decoder
    // ============================================================

    always_comb begin
        id_next        = '0;
        id_next.valid  = 1'b1;
        id_next.pc     = pc;
        id_next.a      = read_reg(rs);
        id_next.b      = read_reg(rt);
        id_next.imm    = {{(xlen-16){instruction[15]}}, instruction[15:0]};
        id_next.rs     = rs;
        id_next.rt     = rt;
        id_next.dest   = rt;
        id_next.alu_op = ALU_ADD;
        uses_rt        = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                id_next.dest      = rd;
                id_next.write_reg = 1'b1;
                uses_rt           = 1'b1;
                case (funct)
                    FN_ADD:  id_next.alu_op = ALU_ADD;
                    FN_SUB:  id_next.alu_op = ALU_SUB;
                    FN_AND:  id_next.alu_op = ALU_AND;
                    FN_OR:   id_next.alu_op = ALU_OR;
                    FN_SLT:  id_next.alu_op = ALU_SLT;
                    default: id_next.write_reg = 1'b0;   // No-op.
                endcase
            end
            OP_ADDI: begin
                id_next.use_imm   = 1'b1;
                id_next.write_reg = 1'b1;
            end
            OP_LW: begin
                id_next.use_imm   = 1'b1;
                id_next.mem_read  = 1'b1;
                id_next.write_reg = 1'b1;
            end
            OP_SW: begin
                id_next.use_imm   = 1'b1;
                id_next.mem_write = 1'b1;
                uses_rt           = 1'b1;             // Store data.
            end
            OP_BEQ: begin
                id_next.branch = 1'b1;
                uses_rt        = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex.bits <= '0;
        end else if (!ex.stall) begin
            ex.bits <= ex.flush ? '0 : id_next;
        end
    end

endmodule

// File: hdl/stage_execute.sv
module stage_execute
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    pipe_if.consumer        ex,
    pipe_if.producer        mem,
    input  fwd_sel_e        fwd_a,
    input  fwd_sel_e        fwd_b,
    input  logic [xlen-1:0] mem_result,
    input  logic [xlen-1:0] wb_result,
    output logic            branch_taken,
    output logic [xlen-1:0] branch_target
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] rt_val;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_out;

    function automatic logic [xlen-1:0] fwd_mux(fwd_sel_e sel, logic [xlen-1:0] reg_val,
                                                logic [xlen-1:0] from_mem,
                                                logic [xlen-1:0] from_wb);
        case (sel)
            FWD_MEM: return from_mem;
            FWD_WB:  return from_wb;
            default: return reg_val;
        endcase
    endfunction

    assign op_a   = fwd_mux(fwd_a, ex.bits.a, mem_result, wb_result);
    assign rt_val = fwd_mux(fwd_b, ex.bits.b, mem_result, wb_result);
    assign op_b   = ex.bits.use_imm ? ex.bits.imm : rt_val;

    always_comb begin
        case (ex.bits.alu_op)
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_SLT: alu_out = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_out = op_a + op_b;
        endcase
    end

    // BEQ compares the forwarded register values, not the ALU result.
    assign branch_taken  = ex.bits.valid & ex.bits.branch & (op_a == rt_val);
    assign branch_target = ex.bits.pc + xlen'(instr_bytes) + {ex.bits.imm[xlen-3:0], 2'b00};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem.bits <= '0;
        end else if (!mem.stall) begin
            if (mem.flush) begin
                mem.bits <= '0;
            end else begin
                mem.bits.valid      <= ex.bits.valid;
                mem.bits.result     <= alu_out;
                mem.bits.store_data <= rt_val;
                mem.bits.dest       <= ex.bits.dest;
                mem.bits.write_reg  <= ex.bits.write_reg;
                mem.bits.mem_read   <= ex.bits.mem_read;
                mem.bits.mem_write  <= ex.bits.mem_write;
            end
        end
    end

endmodule

// File: hdl/stage_memory.sv
module stage_memory
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    pipe_if.consumer        mem,
    input  logic            stall,
    output logic [xlen-1:0] dmem_addr,
    output logic [xlen-1:0] dmem_wdata,
    output logic            dmem_we,
    output logic            dmem_re,
    input  logic [xlen-1:0] dmem_rdata,
    output logic            wb_we,
    output reg_addr_t       wb_dest,
    output logic [xlen-1:0] wb_data,
    output logic [xlen-1:0] mem_result
);

    mem_wb_t wb;

    // Straight from the stage register, so they hold with it.
    assign dmem_addr  = mem.bits.result;
    assign dmem_wdata = mem.bits.store_data;
    assign dmem_we    = mem.bits.valid & mem.bits.mem_write;
    assign dmem_re    = mem.bits.valid & mem.bits.mem_read;
    assign mem_result = mem.bits.result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb <= '0;
        end else if (!stall) begin
            wb.valid     <= mem.bits.valid;
            wb.dest      <= mem.bits.dest;
            wb.write_reg <= mem.bits.write_reg;
            wb.result    <= mem.bits.mem_read ? dmem_rdata : mem.bits.result;
        end
    end

    assign wb_we   = wb.valid & wb.write_reg;
    assign wb_dest = wb.dest;
    assign wb_data = wb.result;

endmodule

// File: hdl/hazard_unit.sv
module hazard_unit
    import core_pkg::*;
(
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    input  logic      uses_rt,
    pipe_if.consumer  ex,
    pipe_if.consumer  mem,
    input  logic      wb_we,
    input  reg_addr_t wb_dest,
    input  logic      dmem_stall,
    input  logic      branch_taken,
    output logic      fetch_stall,
    output logic      fetch_flush,
    output fwd_sel_e  fwd_a,
    output fwd_sel_e  fwd_b
);

    logic      mem_fwd;
    logic      wb_fwd;
    reg_addr_t mem_dest;
    logic      load_use;

    // A load in memory never forwards. The load-use stall keeps it apart.
    assign mem_fwd  = mem.bits.valid & mem.bits.write_reg & ~mem.bits.mem_read
                    & (mem.bits.dest != '0);
    assign mem_dest = mem.bits.dest;
    assign wb_fwd   = wb_we & (wb_dest != '0);

    // Nearest producer wins.
    function automatic fwd_sel_e pick(reg_addr_t src);
        if (mem_fwd && mem_dest == src) begin
            return FWD_MEM;
        end
        if (wb_fwd && wb_dest == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    always_comb begin
        fwd_a = pick(ex.bits.rs);
        fwd_b = pick(ex.bits.rt);
    end

    assign load_use = ex.bits.valid & ex.bits.mem_read & (ex.bits.dest != '0)
                    & ((ex.bits.dest == rs) | (uses_rt & (ex.bits.dest == rt)));

    // Data memory hold freezes everything and masks any flush.
    assign fetch_stall = dmem_stall | load_use;
    assign fetch_flush = branch_taken & ~dmem_stall;
    assign ex.stall    = dmem_stall;
    assign ex.flush    = (branch_taken | load_use) & ~dmem_stall;
    assign mem.stall   = dmem_stall;
    assign mem.flush   = 1'b0;                // Nothing past execute is squashed.

endmodule

// File: hdl/core.sv
module core
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    output logic [xlen-1:0] imem_addr,
    input  logic [xlen-1:0] imem_data,
    output logic [xlen-1:0] dmem_addr,
    output logic [xlen-1:0] dmem_wdata,
    output logic            dmem_we,
    output logic            dmem_re,
    input  logic [xlen-1:0] dmem_rdata,
    input  logic            dmem_stall
);

    pipe_if #(.bits_t(id_ex_t))  ex_if ();
    pipe_if #(.bits_t(ex_mem_t)) mem_if ();

    logic [xlen-1:0] fd_instruction;
    logic [xlen-1:0] fd_pc;
    logic            fetch_stall;
    logic            fetch_flush;
    logic            branch_taken;
    logic [xlen-1:0] branch_target;
    reg_addr_t       rs;
    reg_addr_t       rt;
    logic            uses_rt;
    fwd_sel_e        fwd_a;
    fwd_sel_e        fwd_b;
    logic            wb_we;
    reg_addr_t       wb_dest;
    logic [xlen-1:0] wb_data;
    logic [xlen-1:0] mem_result;

    stage_fetch u_fetch (
        .clk(clk), .arst_n(arst_n),
        .stall(fetch_stall), .load(branch_taken), .pc_in(branch_target),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .instruction(fd_instruction), .pc(fd_pc), .flush(fetch_flush));

    stage_decode u_decode (
        .clk(clk), .arst_n(arst_n),
        .instruction(fd_instruction), .pc(fd_pc),
        .wb_we(wb_we), .wb_dest(wb_dest), .wb_data(wb_data),
        .rs(rs), .rt(rt), .uses_rt(uses_rt), .ex(ex_if.producer));

    stage_execute u_execute (
        .clk(clk), .arst_n(arst_n),
        .ex(ex_if.consumer), .mem(mem_if.producer),
        .fwd_a(fwd_a), .fwd_b(fwd_b),
        .mem_result(mem_result), .wb_result(wb_data),
        .branch_taken(branch_taken), .branch_target(branch_target));

    stage_memory u_memory (
        .clk(clk), .arst_n(arst_n),
        .mem(mem_if.consumer), .stall(mem_if.stall),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .dmem_we(dmem_we), .dmem_re(dmem_re), .dmem_rdata(dmem_rdata),
        .wb_we(wb_we), .wb_dest(wb_dest), .wb_data(wb_data),
        .mem_result(mem_result));

    hazard_unit u_hazard (
        .rs(rs), .rt(rt), .uses_rt(uses_rt),
        .ex(ex_if.consumer), .mem(mem_if.consumer),
        .wb_we(wb_we), .wb_dest(wb_dest),
        .dmem_stall(dmem_stall), .branch_taken(branch_taken),
        .fetch_stall(fetch_stall), .fetch_flush(fetch_flush),
        .fwd_a(fwd_a), .fwd_b(fwd_b));

endmodule

// File: testbench/core_sva.sv
module core_sva
    import core_pkg::*;
(
    input logic            clk,
    input logic            arst_n,
    input logic [xlen-1:0] dmem_addr,
    input logic [xlen-1:0] dmem_wdata,
    input logic            dmem_we,
    input logic            dmem_re,
    input logic            dmem_stall,
    input logic            branch_taken
);

    timeunit 1ns;
    timeprecision 1ps;

    a_we_re : assert property (@(posedge clk) disable iff (!arst_n)
        !(dmem_we && dmem_re))
        else $error("dmem_we and dmem_re high together");

    a_hold : assert property (@(posedge clk) disable iff (!arst_n)
        dmem_stall |=> $stable({dmem_addr, dmem_wdata, dmem_we, dmem_re}))
        else $error("data memory outputs moved during a stall");

    // The branch itself reaches memory first, then the two squashed slots as bubbles.
    a_squash : assert property (@(posedge clk) disable iff (!arst_n)
        branch_taken && !dmem_stall |=> ##1 !dmem_we ##1 !dmem_we)
        else $error("store issued from a squashed slot");

endmodule

bind core core_sva u_sva (
    .clk(clk), .arst_n(arst_n),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
    .dmem_we(dmem_we), .dmem_re(dmem_re),
    .dmem_stall(dmem_stall), .branch_taken(branch_taken));

// File: testbench/tb_core.sv
module tb_core
    import core_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          cycle_limit = 2000;   // Six short programs, stalls and margin.
    localparam logic [31:0] done_addr   = 32'h0000_0ffc;

    logic        clk = 1'b0;
    logic        arst_n = 1'b0;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic        dmem_re;
    logic [31:0] dmem_rdata;
    logic        dmem_stall = 1'b0;

    logic [31:0] imem [256];
    logic [31:0] dmem [1024];
    logic [31:0] log_addr [$];
    logic [31:0] log_data [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [7:0]  n_instr = 8'd0;
    int          cycles = 0;
    int          errors = 0;
    bit          done = 1'b0;
    bit          random_stall = 1'b0;

    core i_core (
        .clk(clk), .arst_n(arst_n),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .dmem_we(dmem_we), .dmem_re(dmem_re), .dmem_rdata(dmem_rdata),
        .dmem_stall(dmem_stall));

    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem_re ? dmem[dmem_addr[11:2]] : 32'h0;   // Data only on a read.

    initial begin
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("** FAIL **");
            $fatal(1, "Timeout after %0d cycles without reaching the final store.", cycles);
        end
    end

    // ============================================================
    // Data memory model and store log
    // ============================================================

    always @(negedge clk) begin
        if (!arst_n) begin
            dmem_stall = 1'b0;
        end else begin
            dmem_stall = random_stall ? ($urandom_range(0, 2) == 0) : 1'b0;
            if (dmem_we && !dmem_stall) begin         // Taken at the next rising edge.
                dmem[dmem_addr[11:2]] = dmem_wdata;
                if (dmem_addr == done_addr) begin
                    done = 1'b1;
                end else begin
                    log_addr.push_back(dmem_addr);
                    log_data.push_back(dmem_wdata);
                end
            end
        end
    end

    function automatic logic [31:0] rtype(funct_e fn, reg_addr_t rd, reg_addr_t rs,
                                          reg_addr_t rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] itype(opcode_e op, reg_addr_t rt, reg_addr_t rs,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Background data, taken from the byte address.
    function automatic logic [31:0] fill_word(logic [31:0] addr);
        return {addr[15:0], ~addr[15:0]};
    endfunction

    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("** FAIL **");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    task automatic emit(logic [31:0] word);
        imem[n_instr] = word;
        n_instr       = n_instr + 8'd1;
    endtask

    task automatic expect_store(logic [31:0] addr, logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic start_program(bit stalls);
        foreach (imem[i]) imem[i] = 32'h0;        // Zero decodes as a no-op.
        foreach (dmem[i]) dmem[i] = fill_word(32'(i) << 2);
        log_addr.delete();
        log_data.delete();
        exp_addr.delete();
        exp_data.delete();
        n_instr      = 8'd0;
        done         = 1'b0;
        random_stall = stalls;
    endtask

    task automatic apply_reset();
        arst_n = 1'b0;
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
    endtask

    task automatic compare_stores();
        check("store count", 32'(log_addr.size()), 32'(exp_addr.size()));
        foreach (exp_addr[i]) begin
            check($sformatf("dmem_addr (store %0d)", i), log_addr[i], exp_addr[i]);
            check($sformatf("dmem_wdata (store %0d)", i), log_data[i], exp_data[i]);
        end
    endtask

    task automatic run_program();
        emit(itype(OP_SW, 0, 0, done_addr[15:0]));
        apply_reset();
        wait (done);
        @(negedge clk);
        compare_stores();
    endtask

    // ============================================================
    // Directed tests
    // ============================================================

    task automatic reset_state();
        start_program(1'b0);
        emit(itype(OP_SW, 0, 0, 16'h0700));
        emit(itype(OP_LW, 1, 0, 16'h0700));
        apply_reset();
        repeat (3) @(negedge clk);
        check("dmem_we", 32'(dmem_we), 32'h1);    // Store sits in memory.
        @(negedge clk);
        check("dmem_re", 32'(dmem_re), 32'h1);    // Then the load.
        check("imem_addr", imem_addr, 32'h10);
        arst_n = 1'b0;
        #1;
        check("dmem_we", 32'(dmem_we), 32'h0);
        check("dmem_re", 32'(dmem_re), 32'h0);
        check("imem_addr", imem_addr, 32'h0);
    endtask

    task automatic alu_program();
        int a;
        int b;
        a = 25;
        b = -7;
        start_program(1'b0);
        emit(itype(OP_ADDI, 1, 0, 16'd25));
        emit(itype(OP_ADDI, 2, 0, 16'hfff9));
        repeat (3) emit(32'h0);
        emit(rtype(FN_ADD, 3, 1, 2));
        emit(rtype(FN_SUB, 4, 1, 2));
        emit(rtype(FN_AND, 5, 1, 2));
        emit(rtype(FN_OR, 6, 1, 2));
        emit(rtype(FN_SLT, 7, 2, 1));
        emit(rtype(FN_SLT, 8, 1, 2));
        repeat (3) emit(32'h0);
        for (int r = 3; r <= 8; r++) begin
            emit(itype(OP_SW, 5'(r), 0, 16'h0100 + 16'(4 * r)));
        end
        expect_store(32'h10c, a + b);
        expect_store(32'h110, a - b);
        expect_store(32'h114, a & b);
        expect_store(32'h118, a | b);
        expect_store(32'h11c, (b < a) ? 1 : 0);
        expect_store(32'h120, (a < b) ? 1 : 0);
        run_program();
    endtask

    task automatic forwarding_program(bit stalls);
        int v1;
        int v2;
        int v3;
        int v4;
        int v5;
        int v6;
        int v7;
        v1 = 10;
        v2 = v1 + 5;
        v3 = v1 + 1;
        v6 = v1 + 2;
        v4 = v2 + v3;
        v5 = v4 | v6;
        v7 = v5 - v4;
        start_program(stalls);
        emit(itype(OP_ADDI, 1, 0, 16'd10));
        emit(itype(OP_ADDI, 2, 1, 16'd5));        // Distance 1.
        emit(itype(OP_ADDI, 3, 1, 16'd1));        // Distance 2.
        emit(itype(OP_ADDI, 6, 1, 16'd2));        // Distance 3.
        emit(rtype(FN_ADD, 4, 2, 3));
        emit(rtype(FN_OR, 5, 4, 6));
        emit(itype(OP_SW, 5, 0, 16'h0200));
        emit(itype(OP_SW, 4, 0, 16'h0204));
        emit(rtype(FN_SUB, 7, 5, 4));
        emit(itype(OP_SW, 7, 0, 16'h0208));
        emit(itype(OP_ADDI, 8, 0, 16'h0300));
        emit(itype(OP_SW, 6, 8, 16'h0000));       // Forwarded base.
        expect_store(32'h200, v5);
        expect_store(32'h204, v4);
        expect_store(32'h208, v7);
        expect_store(32'h300, v6);
        run_program();
    endtask

    task automatic load_use_program();
        start_program(1'b0);
        emit(itype(OP_ADDI, 1, 0, 16'h0040));
        emit(itype(OP_ADDI, 2, 0, 16'd7));
        emit(itype(OP_LW, 3, 1, 16'h0010));
        emit(rtype(FN_ADD, 4, 3, 2));
        emit(itype(OP_SW, 4, 0, 16'h0400));
        emit(itype(OP_LW, 5, 0, 16'h0020));
        emit(rtype(FN_ADD, 6, 2, 5));
        emit(itype(OP_SW, 6, 0, 16'h0404));
        emit(itype(OP_LW, 7, 0, 16'h0060));
        emit(itype(OP_SW, 7, 0, 16'h0408));
        expect_store(32'h400, fill_word(32'h50) + 7);
        expect_store(32'h404, fill_word(32'h20) + 7);
        expect_store(32'h408, fill_word(32'h60));
        run_program();
    endtask

    task automatic branch_program();
        start_program(1'b0);
        emit(itype(OP_ADDI, 1, 0, 16'd3));
        emit(itype(OP_ADDI, 2, 0, 16'd3));
        emit(itype(OP_ADDI, 3, 0, 16'd4));
        emit(itype(OP_BEQ, 3, 1, 16'd2));         // Not taken.
        emit(itype(OP_SW, 1, 0, 16'h0500));
        emit(itype(OP_BEQ, 2, 1, 16'd3));         // Taken, skips three.
        emit(itype(OP_SW, 2, 0, 16'h0504));
        emit(itype(OP_SW, 3, 0, 16'h0508));
        emit(itype(OP_SW, 3, 0, 16'h050c));
        emit(itype(OP_SW, 3, 0, 16'h0510));
        expect_store(32'h500, 32'd3);
        expect_store(32'h510, 32'd4);
        run_program();
    endtask

    initial begin
        void'($urandom(32'h9052_aa1c));
        reset_state();
        alu_program();
        forwarding_program(1'b0);
        load_use_program();
        branch_program();
        forwarding_program(1'b1);
        if (errors == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("** FAIL **");
            $fatal(1, "%0d checks failed.", errors);
        end
    end

endmodule

// File: list.f
hdl/core_pkg.sv
hdl/pipe_if.sv
hdl/stage_fetch.sv
hdl/stage_decode.sv
hdl/stage_execute.sv
hdl/stage_memory.sv
hdl/hazard_unit.sv
hdl/core.sv
testbench/core_sva.sv
testbench/tb_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_core -f list.f
./obj_dir/Vtb_core
